// File: verilog.f
+incdir+dv
source/ecc_bank_pkg.sv
source/secded_codec.sv
source/sram_array.sv
source/ecc_sram_wrap.sv
source/ecc_scrubber_out.sv
source/ecc_scrubbed_bank.sv
dv/tb_ecc_scrubbed_bank.sv

// File: Bender.yml
package:
  name: ecc_scrubbed_bank

sources:
  - files:
      - source/ecc_bank_pkg.sv
      - source/secded_codec.sv
      - source/sram_array.sv
      - source/ecc_sram_wrap.sv
      - source/ecc_scrubber_out.sv
      - source/ecc_scrubbed_bank.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_ecc_scrubbed_bank.sv

// File: dv/tb_ecc_stim.svh
// ECC bank stimulus table
`ifndef TB_ECC_STIM_SVH
`define TB_ECC_STIM_SVH

typedef enum logic [1:0] {
  OpWrite,
  OpRead,
  OpScrub
} op_e;

typedef struct {
  op_e                    op;
  logic                   bank;       // 1 is the data bank
  int unsigned            addr;       // Number of scrubs for OpScrub
  ecc_bank_pkg::data_be_t be;
  ecc_bank_pkg::data_t    wdata;
  int unsigned            inj_bits;
  ecc_bank_pkg::data_t    exp_rdata;
  logic                   exp_multi;  // Any uncorrectable pulse for OpScrub
  int unsigned            exp_pulse;
} stim_t;

stim_t       stim_q[$];
logic [31:0] lcg_state = 32'hc63e;

// Reference model of both banks, indexed by bank then address
ecc_bank_pkg::data_t shadow_q [2][ecc_bank_pkg::DataDepth];
logic                single_q [2][ecc_bank_pkg::DataDepth];
logic                multi_q  [2][ecc_bank_pkg::DataDepth];
int unsigned         scrub_pos = 0;

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

function automatic void add_write(input logic bank, input int unsigned addr,
                                  input ecc_bank_pkg::data_be_t be, input int unsigned inj);
  stim_t       s;
  logic [31:0] rnd;
  rnd         = lcg_next();
  s.op        = OpWrite;
  s.bank      = bank;
  s.addr      = addr;
  s.be        = be;
  s.inj_bits  = inj;
  s.wdata     = bank ? rnd : {16'h0, rnd[31:16]};
  // Only a partial write reads the old word, so only it can flag a bad one
  s.exp_multi = !(&be) && multi_q[bank][addr];
  s.exp_rdata = '0;
  s.exp_pulse = 0;
  for (int unsigned b = 0; b < ecc_bank_pkg::NumBytes; b++) begin
    if (be[b]) begin
      shadow_q[bank][addr][8*b +: 8] = s.wdata[8*b +: 8];
    end
  end
  single_q[bank][addr] = (inj == 1);
  multi_q[bank][addr]  = (inj == 2);
  stim_q.push_back(s);
endfunction

function automatic void add_read(input logic bank, input int unsigned addr);
  stim_t s;
  s.op        = OpRead;
  s.bank      = bank;
  s.addr      = addr;
  s.be        = '0;
  s.wdata     = '0;
  s.inj_bits  = 0;
  s.exp_rdata = shadow_q[bank][addr];
  s.exp_multi = multi_q[bank][addr];
  s.exp_pulse = 0;
  // The wrapper rewrites a corrected word on the way out
  single_q[bank][addr] = 1'b0;
  stim_q.push_back(s);
endfunction

function automatic void add_scrub(input int unsigned count);
  stim_t       s;
  int unsigned t;
  s.op        = OpScrub;
  s.bank      = 1'b0;
  s.addr      = count;
  s.be        = '0;
  s.wdata     = '0;
  s.inj_bits  = 0;
  s.exp_rdata = '0;
  s.exp_multi = 1'b0;
  s.exp_pulse = 0;
  for (int unsigned i = 0; i < count; i++) begin
    t = scrub_pos / ecc_bank_pkg::BlocksPerIndex;
    if (single_q[1][scrub_pos] || single_q[0][t]) begin
      s.exp_pulse++;
    end
    if (multi_q[1][scrub_pos] || multi_q[0][t]) begin
      s.exp_multi = 1'b1;
    end
    single_q[1][scrub_pos] = 1'b0;
    single_q[0][t]         = 1'b0;
    scrub_pos = (scrub_pos + 1) % ecc_bank_pkg::DataDepth;
  end
  stim_q.push_back(s);
endfunction

function automatic void build_table();
  // Fill and read back every entry
  for (int unsigned a = 0; a < ecc_bank_pkg::TagDepth; a++) begin
    add_write(1'b0, a, 4'hf, 0);
  end
  for (int unsigned a = 0; a < ecc_bank_pkg::DataDepth; a++) begin
    add_write(1'b1, a, 4'hf, 0);
  end
  for (int unsigned a = 0; a < ecc_bank_pkg::TagDepth; a++) begin
    add_read(1'b0, a);
  end
  for (int unsigned a = 0; a < ecc_bank_pkg::DataDepth; a++) begin
    add_read(1'b1, a);
  end
  // Single flip, corrected and written back
  add_write(1'b1, 5, 4'hf, 1);
  add_read(1'b1, 5);
  add_read(1'b1, 5);
  // Double flip
  add_write(1'b1, 9, 4'hf, 2);
  add_read(1'b1, 9);
  // Byte merges, then a merge onto the bad word
  add_write(1'b1, 12, 4'b0101, 0);
  add_read(1'b1, 12);
  add_write(1'b1, 12, 4'b1000, 0);
  add_read(1'b1, 12);
  add_write(1'b1, 9, 4'b0011, 0);
  add_write(1'b1, 9, 4'hf, 0);
  add_read(1'b1, 9);
  // Two full sweeps over one single flip
  add_write(1'b1, 33, 4'hf, 1);
  add_scrub(ecc_bank_pkg::DataDepth);
  add_scrub(ecc_bank_pkg::DataDepth);
  // Bad tag entry with reads between quarter sweeps
  add_write(1'b0, 2, 4'hf, 2);
  for (int unsigned q = 0; q < 4; q++) begin
    add_scrub(ecc_bank_pkg::DataDepth / 4);
    add_read(1'b1, 7 * q + 3);
    add_read(1'b0, 3 * q + 1);
  end
  add_read(1'b0, 2);
endfunction

`endif

// File: dv/tb_ecc_scrubbed_bank.sv
// ECC scrubbed bank testbench
`timescale 1ns/100ps
`default_nettype none

module tb_ecc_scrubbed_bank;

  localparam int unsigned GntWaitCycles = 16;

  logic                     clk_i = 1'b0;
  logic                     rst_ni;
  logic                     scrub_trigger_i;
  logic                     bit_corrected_o;
  logic                     uncorrectable_o;
  logic                     tag_intc_req_i;
  logic                     tag_intc_we_i;
  logic                     tag_intc_be_i;
  ecc_bank_pkg::tag_addr_t  tag_intc_add_i;
  ecc_bank_pkg::tag_t       tag_intc_wdata_i;
  logic                     tag_intc_gnt_o;
  ecc_bank_pkg::tag_t       tag_intc_rdata_o;
  logic                     tag_intc_multi_err_o;
  logic                     data_intc_req_i;
  logic                     data_intc_we_i;
  ecc_bank_pkg::data_be_t   data_intc_be_i;
  ecc_bank_pkg::data_addr_t data_intc_add_i;
  ecc_bank_pkg::data_t      data_intc_wdata_i;
  logic                     data_intc_gnt_o;
  ecc_bank_pkg::data_t      data_intc_rdata_o;
  logic                     data_intc_multi_err_o;
  ecc_bank_pkg::tag_cw_t    tag_inj_i;
  ecc_bank_pkg::data_cw_t   data_inj_i;
  logic                     table_built = 1'b0;

  `include "tb_ecc_stim.svh"

  ecc_scrubbed_bank UUT (.*);

  always #2 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      abort_run($sformatf("ERR %0t ns %s expected %h got %h", $time, name, exp, got));
    end
  endtask

  // Adjacent flips from a random start, so two bits are always distinct
  function automatic logic [63:0] flip_mask(input int unsigned bits, input int unsigned width);
    logic [63:0] mask;
    int unsigned pos;
    mask = '0;
    pos  = lcg_next() % width;
    for (int unsigned i = 0; i < bits; i++) begin
      mask[(pos + i) % width] = 1'b1;
    end
    return mask;
  endfunction

  // Compare the read port against the expected response of a read row
  task automatic check_read_port(input stim_t s);
    ecc_bank_pkg::data_t got_rdata;
    logic                got_multi;
    got_rdata = s.bank ? data_intc_rdata_o : ecc_bank_pkg::data_t'(tag_intc_rdata_o);
    got_multi = s.bank ? data_intc_multi_err_o : tag_intc_multi_err_o;
    check_value(s.bank ? "data_intc_multi_err_o" : "tag_intc_multi_err_o",
                s.exp_multi, got_multi);
    if (!s.exp_multi) begin
      check_value(s.bank ? "data_intc_rdata_o" : "tag_intc_rdata_o", s.exp_rdata, got_rdata);
    end
  endtask

  task automatic run_access(input stim_t s);
    logic [63:0] mask;
    int unsigned waited;
    mask = flip_mask(s.inj_bits, s.bank ? ecc_bank_pkg::DataCodeWidth
                                        : ecc_bank_pkg::TagCodeWidth);
    @(posedge clk_i);
    if (s.bank) begin
      data_intc_req_i   <= 1'b1;
      data_intc_we_i    <= (s.op == OpWrite);
      data_intc_be_i    <= s.be;
      data_intc_add_i   <= ecc_bank_pkg::data_addr_t'(s.addr);
      data_intc_wdata_i <= s.wdata;
      data_inj_i        <= ecc_bank_pkg::data_cw_t'(mask);
    end else begin
      tag_intc_req_i   <= 1'b1;
      tag_intc_we_i    <= (s.op == OpWrite);
      tag_intc_be_i    <= s.be[0];
      tag_intc_add_i   <= ecc_bank_pkg::tag_addr_t'(s.addr);
      tag_intc_wdata_i <= ecc_bank_pkg::tag_t'(s.wdata);
      tag_inj_i        <= ecc_bank_pkg::tag_cw_t'(mask);
    end
    // Accepted on the next rising edge that sees gnt high
    waited = 0;
    @(negedge clk_i);
    while (!(s.bank ? data_intc_gnt_o : tag_intc_gnt_o)) begin
      waited++;
      if (waited > GntWaitCycles) begin
        abort_run("The bank did not grant a request within the wait limit");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    tag_intc_req_i  <= 1'b0;
    data_intc_req_i <= 1'b0;
    tag_inj_i       <= '0;
    data_inj_i      <= '0;
    @(negedge clk_i);
    if (s.op == OpRead) begin
      check_read_port(s);
      // Response stays on the port after the read cycle
      @(posedge clk_i);
      @(negedge clk_i);
      check_read_port(s);
    end else if (s.bank) begin
      check_value("data_intc_multi_err_o", s.exp_multi, data_intc_multi_err_o);
    end
  endtask

  // Idle, Read and Check take three cycles per scrub on a quiet bus
  task automatic run_scrub(input stim_t s);
    int unsigned fixed;
    int unsigned unfixable;
    fixed     = 0;
    unfixable = 0;
    @(posedge clk_i);
    scrub_trigger_i <= 1'b1;
    repeat (3 * s.addr) begin
      @(negedge clk_i);
      if (bit_corrected_o) begin
        fixed++;
      end
      if (uncorrectable_o) begin
        unfixable++;
      end
      @(posedge clk_i);
    end
    scrub_trigger_i <= 1'b0;
    check_value("bit_corrected_o pulses", s.exp_pulse, fixed);
    check_value("uncorrectable_o seen", s.exp_multi, unfixable != 0);
  endtask

  initial begin : run
    rst_ni            = 1'b0;
    scrub_trigger_i   = 1'b0;
    tag_intc_req_i    = 1'b0;
    tag_intc_we_i     = 1'b0;
    tag_intc_be_i     = 1'b0;
    tag_intc_add_i    = '0;
    tag_intc_wdata_i  = '0;
    data_intc_req_i   = 1'b0;
    data_intc_we_i    = 1'b0;
    data_intc_be_i    = '0;
    data_intc_add_i   = '0;
    data_intc_wdata_i = '0;
    tag_inj_i         = '0;
    data_inj_i        = '0;
    build_table();
    table_built = 1'b1;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    foreach (stim_q[i]) begin
      if (stim_q[i].op == OpScrub) begin
        run_scrub(stim_q[i]);
      end else begin
        run_access(stim_q[i]);
      end
    end
    repeat (2) @(posedge clk_i);
    $display("** PASS **");
    $finish;
  end

  initial begin : watchdog
    wait (table_built);
    repeat (stim_q.size() * 200) @(posedge clk_i);
    abort_run("Timeout, the stimulus table did not finish in time");
  end

endmodule

`default_nettype wire

// File: source/ecc_scrubbed_bank.sv
// Scrubbed ECC cache bank
`timescale 1ns/100ps
`default_nettype none

module ecc_scrubbed_bank (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     scrub_trigger_i,
  output logic                     bit_corrected_o,
  output logic                     uncorrectable_o,

  input  logic                     tag_intc_req_i,
  input  logic                     tag_intc_we_i,
  input  logic                     tag_intc_be_i,
  input  ecc_bank_pkg::tag_addr_t  tag_intc_add_i,
  input  ecc_bank_pkg::tag_t       tag_intc_wdata_i,
  output logic                     tag_intc_gnt_o,
  output ecc_bank_pkg::tag_t       tag_intc_rdata_o,
  output logic                     tag_intc_multi_err_o,

  input  logic                     data_intc_req_i,
  input  logic                     data_intc_we_i,
  input  ecc_bank_pkg::data_be_t   data_intc_be_i,
  input  ecc_bank_pkg::data_addr_t data_intc_add_i,
  input  ecc_bank_pkg::data_t      data_intc_wdata_i,
  output logic                     data_intc_gnt_o,
  output ecc_bank_pkg::data_t      data_intc_rdata_o,
  output logic                     data_intc_multi_err_o,

  input  ecc_bank_pkg::tag_cw_t    tag_inj_i,
  input  ecc_bank_pkg::data_cw_t   data_inj_i
);

  // Scrubber to wrapper
  logic                     tag_bank_req, tag_bank_gnt, tag_bank_we, tag_bank_be;
  logic                     tag_bank_single_err, tag_bank_multi_err;
  ecc_bank_pkg::tag_addr_t  tag_bank_add;
  ecc_bank_pkg::tag_t       tag_bank_wdata, tag_bank_rdata;
  logic                     data_bank_req, data_bank_gnt, data_bank_we;
  logic                     data_bank_single_err, data_bank_multi_err;
  ecc_bank_pkg::data_be_t   data_bank_be;
  ecc_bank_pkg::data_addr_t data_bank_add;
  ecc_bank_pkg::data_t      data_bank_wdata, data_bank_rdata;

  // Wrapper to array
  logic                     tag_mem_req, tag_mem_we, data_mem_req, data_mem_we;
  ecc_bank_pkg::tag_addr_t  tag_mem_add;
  ecc_bank_pkg::data_addr_t data_mem_add;
  ecc_bank_pkg::tag_cw_t    tag_mem_wdata, tag_mem_rdata;
  ecc_bank_pkg::data_cw_t   data_mem_wdata, data_mem_rdata;

  ecc_scrubber_out i_scrubber (
    .clk_i, .rst_ni, .scrub_trigger_i, .bit_corrected_o, .uncorrectable_o,
    .tag_intc_req_i, .tag_intc_we_i, .tag_intc_be_i, .tag_intc_add_i, .tag_intc_wdata_i,
    .tag_intc_gnt_o, .tag_intc_rdata_o, .tag_intc_multi_err_o,
    .data_intc_req_i, .data_intc_we_i, .data_intc_be_i, .data_intc_add_i,
    .data_intc_wdata_i, .data_intc_gnt_o, .data_intc_rdata_o, .data_intc_multi_err_o,
    .tag_bank_req_o        (tag_bank_req),
    .tag_bank_gnt_i        (tag_bank_gnt),
    .tag_bank_we_o         (tag_bank_we),
    .tag_bank_be_o         (tag_bank_be),
    .tag_bank_add_o        (tag_bank_add),
    .tag_bank_wdata_o      (tag_bank_wdata),
    .tag_bank_rdata_i      (tag_bank_rdata),
    .tag_bank_single_err_i (tag_bank_single_err),
    .tag_bank_multi_err_i  (tag_bank_multi_err),
    .data_bank_req_o       (data_bank_req),
    .data_bank_gnt_i       (data_bank_gnt),
    .data_bank_we_o        (data_bank_we),
    .data_bank_be_o        (data_bank_be),
    .data_bank_add_o       (data_bank_add),
    .data_bank_wdata_o     (data_bank_wdata),
    .data_bank_rdata_i     (data_bank_rdata),
    .data_bank_single_err_i(data_bank_single_err),
    .data_bank_multi_err_i (data_bank_multi_err)
  );

  // Tag words are written whole, so one enable covers the entry
  ecc_sram_wrap #(
    .DataWidth(ecc_bank_pkg::TagWidth),
    .CodeWidth(ecc_bank_pkg::TagCodeWidth),
    .Depth    (ecc_bank_pkg::TagDepth),
    .NumBytes (1)
  ) i_tag_wrap (
    .clk_i, .rst_ni,
    .req_i       (tag_bank_req),
    .we_i        (tag_bank_we),
    .be_i        (tag_bank_be),
    .add_i       (tag_bank_add),
    .wdata_i     (tag_bank_wdata),
    .inj_i       (tag_inj_i),
    .mem_rdata_i (tag_mem_rdata),
    .gnt_o       (tag_bank_gnt),
    .rdata_o     (tag_bank_rdata),
    .single_err_o(tag_bank_single_err),
    .multi_err_o (tag_bank_multi_err),
    .mem_req_o   (tag_mem_req),
    .mem_we_o    (tag_mem_we),
    .mem_add_o   (tag_mem_add),
    .mem_wdata_o (tag_mem_wdata)
  );

  ecc_sram_wrap #(
    .DataWidth(ecc_bank_pkg::DataWidth),
    .CodeWidth(ecc_bank_pkg::DataCodeWidth),
    .Depth    (ecc_bank_pkg::DataDepth),
    .NumBytes (ecc_bank_pkg::NumBytes)
  ) i_data_wrap (
    .clk_i, .rst_ni,
    .req_i       (data_bank_req),
    .we_i        (data_bank_we),
    .be_i        (data_bank_be),
    .add_i       (data_bank_add),
    .wdata_i     (data_bank_wdata),
    .inj_i       (data_inj_i),
    .mem_rdata_i (data_mem_rdata),
    .gnt_o       (data_bank_gnt),
    .rdata_o     (data_bank_rdata),
    .single_err_o(data_bank_single_err),
    .multi_err_o (data_bank_multi_err),
    .mem_req_o   (data_mem_req),
    .mem_we_o    (data_mem_we),
    .mem_add_o   (data_mem_add),
    .mem_wdata_o (data_mem_wdata)
  );

  sram_array #(
    .DataWidth(ecc_bank_pkg::TagWidth),
    .CodeWidth(ecc_bank_pkg::TagCodeWidth),
    .Depth    (ecc_bank_pkg::TagDepth)
  ) i_tag_sram (
    .clk_i,
    .req_i  (tag_mem_req),
    .we_i   (tag_mem_we),
    .addr_i (tag_mem_add),
    .wdata_i(tag_mem_wdata),
    .rdata_o(tag_mem_rdata)
  );

  sram_array #(
    .DataWidth(ecc_bank_pkg::DataWidth),
    .CodeWidth(ecc_bank_pkg::DataCodeWidth),
    .Depth    (ecc_bank_pkg::DataDepth)
  ) i_data_sram (
    .clk_i,
    .req_i  (data_mem_req),
    .we_i   (data_mem_we),
    .addr_i (data_mem_add),
    .wdata_i(data_mem_wdata),
    .rdata_o(data_mem_rdata)
  );

endmodule

`default_nettype wire

// File: source/ecc_scrubber_out.sv
// Bank scrubber and port multiplexer
`timescale 1ns/100ps
`default_nettype none

module ecc_scrubber_out (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     scrub_trigger_i,
  output logic                     bit_corrected_o,
  output logic                     uncorrectable_o,

  input  logic                     tag_intc_req_i,
  input  logic                     tag_intc_we_i,
  input  logic                     tag_intc_be_i,
  input  ecc_bank_pkg::tag_addr_t  tag_intc_add_i,
  input  ecc_bank_pkg::tag_t       tag_intc_wdata_i,
  output logic                     tag_intc_gnt_o,
  output ecc_bank_pkg::tag_t       tag_intc_rdata_o,
  output logic                     tag_intc_multi_err_o,

  input  logic                     data_intc_req_i,
  input  logic                     data_intc_we_i,
  input  ecc_bank_pkg::data_be_t   data_intc_be_i,
  input  ecc_bank_pkg::data_addr_t data_intc_add_i,
  input  ecc_bank_pkg::data_t      data_intc_wdata_i,
  output logic                     data_intc_gnt_o,
  output ecc_bank_pkg::data_t      data_intc_rdata_o,
  output logic                     data_intc_multi_err_o,

  output logic                     tag_bank_req_o,
  input  logic                     tag_bank_gnt_i,
  output logic                     tag_bank_we_o,
  output logic                     tag_bank_be_o,
  output ecc_bank_pkg::tag_addr_t  tag_bank_add_o,
  output ecc_bank_pkg::tag_t       tag_bank_wdata_o,
  input  ecc_bank_pkg::tag_t       tag_bank_rdata_i,
  input  logic                     tag_bank_single_err_i,
  input  logic                     tag_bank_multi_err_i,

  output logic                     data_bank_req_o,
  input  logic                     data_bank_gnt_i,
  output logic                     data_bank_we_o,
  output ecc_bank_pkg::data_be_t   data_bank_be_o,
  output ecc_bank_pkg::data_addr_t data_bank_add_o,
  output ecc_bank_pkg::data_t      data_bank_wdata_o,
  input  ecc_bank_pkg::data_t      data_bank_rdata_i,
  input  logic                     data_bank_single_err_i,
  input  logic                     data_bank_multi_err_i
);

  ecc_bank_pkg::scrub_state_e state_d, state_q;
  ecc_bank_pkg::data_addr_t   working_add_d, working_add_q;

  logic                scrub_req;
  logic                tag_rd_en, tag_rd_en_q;
  logic                data_rd_en, data_rd_en_q;
  logic                data_wr_en, data_wr_en_q;
  logic                data_resp;
  ecc_bank_pkg::tag_t  tag_rdata_q;
  ecc_bank_pkg::data_t data_rdata_q;
  logic                tag_multi_err_q;
  logic                data_multi_err_q;

  // Accepted interconnect accesses, answered one cycle later
  assign tag_rd_en  = tag_intc_req_i & tag_bank_gnt_i & ~tag_intc_we_i;
  assign data_rd_en = data_intc_req_i & data_bank_gnt_i & ~data_intc_we_i;
  assign data_wr_en = data_intc_req_i & data_bank_gnt_i & data_intc_we_i;
  // Partial data writes can still report an uncorrectable old word
  assign data_resp  = data_rd_en_q | data_wr_en_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tag_rd_en_q  <= 1'b0;
      data_rd_en_q <= 1'b0;
      data_wr_en_q <= 1'b0;
    end else begin
      tag_rd_en_q  <= tag_rd_en;
      data_rd_en_q <= data_rd_en;
      data_wr_en_q <= data_wr_en;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tag_multi_err_q  <= 1'b0;
      data_multi_err_q <= 1'b0;
    end else begin
      if (tag_rd_en_q) begin
        tag_multi_err_q <= tag_bank_multi_err_i;
      end
      if (data_resp) begin
        data_multi_err_q <= data_bank_multi_err_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tag_rd_en_q) begin
      tag_rdata_q <= tag_bank_rdata_i;
    end
    if (data_rd_en_q) begin
      data_rdata_q <= data_bank_rdata_i;
    end
  end

  assign tag_intc_gnt_o        = tag_bank_gnt_i;
  assign tag_intc_rdata_o      = tag_rd_en_q ? tag_bank_rdata_i : tag_rdata_q;
  assign tag_intc_multi_err_o  = tag_rd_en_q ? tag_bank_multi_err_i : tag_multi_err_q;
  assign data_intc_gnt_o       = data_bank_gnt_i;
  assign data_intc_rdata_o     = data_rd_en_q ? data_bank_rdata_i : data_rdata_q;
  assign data_intc_multi_err_o = data_resp ? data_bank_multi_err_i : data_multi_err_q;

  assign tag_bank_req_o    = tag_intc_req_i | scrub_req;
  assign data_bank_req_o   = data_intc_req_i | scrub_req;
  assign tag_bank_wdata_o  = tag_intc_wdata_i;
  assign data_bank_wdata_o = data_intc_wdata_i;

  // Interconnect owns both banks unless the scrubber issues its read
  always_comb begin
    tag_bank_we_o   = tag_intc_we_i;
    tag_bank_be_o   = tag_intc_be_i;
    tag_bank_add_o  = tag_intc_add_i;
    data_bank_we_o  = data_intc_we_i;
    data_bank_be_o  = data_intc_be_i;
    data_bank_add_o = data_intc_add_i;
    if (scrub_req) begin
      tag_bank_we_o   = 1'b0;
      tag_bank_be_o   = 1'b0;
      tag_bank_add_o  = ecc_bank_pkg::tag_addr_t'(working_add_q / ecc_bank_pkg::BlocksPerIndex);
      data_bank_we_o  = 1'b0;
      data_bank_be_o  = '0;
      data_bank_add_o = working_add_q;
    end
  end

  always_comb begin
    state_d         = state_q;
    working_add_d   = working_add_q;
    scrub_req       = 1'b0;
    bit_corrected_o = 1'b0;
    uncorrectable_o = 1'b0;
    unique case (state_q)
      ecc_bank_pkg::Idle: begin
        if (scrub_trigger_i) begin
          state_d = ecc_bank_pkg::Read;
        end
      end
      ecc_bank_pkg::Read: begin
        // Stall until both banks are free of traffic
        if (!tag_intc_req_i && !data_intc_req_i && tag_bank_gnt_i && data_bank_gnt_i) begin
          scrub_req = 1'b1;
          state_d   = ecc_bank_pkg::Check;
        end
      end
      ecc_bank_pkg::Check: begin
        bit_corrected_o = tag_bank_single_err_i | data_bank_single_err_i;
        uncorrectable_o = tag_bank_multi_err_i | data_bank_multi_err_i;
        working_add_d   = ecc_bank_pkg::data_addr_t'((working_add_q + 1) %
                                                     ecc_bank_pkg::DataDepth);
        state_d         = ecc_bank_pkg::Idle;
      end
      default: state_d = ecc_bank_pkg::Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= ecc_bank_pkg::Idle;
      working_add_q <= '0;
    end else begin
      state_q       <= state_d;
      working_add_q <= working_add_d;
    end
  end

endmodule

`default_nettype wire

// File: source/ecc_sram_wrap.sv
// SECDED SRAM wrapper
`timescale 1ns/100ps
`default_nettype none

module ecc_sram_wrap #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned CodeWidth = 39,
  parameter int unsigned Depth     = 64,
  parameter int unsigned NumBytes  = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [NumBytes-1:0]      be_i,
  input  logic [$clog2(Depth)-1:0] add_i,
  input  logic [DataWidth-1:0]     wdata_i,
  input  logic [CodeWidth-1:0]     inj_i,
  input  logic [CodeWidth-1:0]     mem_rdata_i,
  output logic                     gnt_o,
  output logic [DataWidth-1:0]     rdata_o,
  output logic                     single_err_o,
  output logic                     multi_err_o,
  output logic                     mem_req_o,
  output logic                     mem_we_o,
  output logic [$clog2(Depth)-1:0] mem_add_o,
  output logic [CodeWidth-1:0]     mem_wdata_o
);

  localparam int unsigned ByteWidth = DataWidth / NumBytes;

  ecc_bank_pkg::wrap_state_e state_d, state_q;

  logic [$clog2(Depth)-1:0] add_q;
  logic [DataWidth-1:0]     wdata_q;
  logic [NumBytes-1:0]      be_q;
  logic [DataWidth-1:0]     enc_data;
  logic [CodeWidth-1:0]     enc_code;
  logic [DataWidth-1:0]     dec_data;
  logic [DataWidth-1:0]     merged;
  logic                     dec_single;
  logic                     dec_multi;
  logic                     resp_valid;

  secded_codec #(
    .DataWidth(DataWidth),
    .CodeWidth(CodeWidth),
    .Depth    (Depth)
  ) i_encoder (
    .enc_data_i  (enc_data),
    .enc_code_o  (enc_code),
    .dec_code_i  ('0),
    .dec_data_o  (),
    .single_err_o(),
    .multi_err_o ()
  );

  secded_codec #(
    .DataWidth(DataWidth),
    .CodeWidth(CodeWidth),
    .Depth    (Depth)
  ) i_decoder (
    .enc_data_i  ('0),
    .enc_code_o  (),
    .dec_code_i  (mem_rdata_i),
    .dec_data_o  (dec_data),
    .single_err_o(dec_single),
    .multi_err_o (dec_multi)
  );

  // Both non-Serve states are the response cycle of a bank read
  assign resp_valid   = (state_q != ecc_bank_pkg::Serve);
  assign gnt_o        = ~resp_valid;
  assign rdata_o      = dec_data;
  assign single_err_o = resp_valid & dec_single;
  assign multi_err_o  = resp_valid & dec_multi;

  // Fault mask applies to every word going into the array
  assign mem_wdata_o = enc_code ^ inj_i;

  always_comb begin
    for (int unsigned b = 0; b < NumBytes; b++) begin
      merged[b*ByteWidth +: ByteWidth] = be_q[b] ? wdata_q[b*ByteWidth +: ByteWidth]
                                                 : dec_data[b*ByteWidth +: ByteWidth];
    end
  end

  always_comb begin
    state_d   = state_q;
    mem_req_o = 1'b0;
    mem_we_o  = 1'b0;
    mem_add_o = add_i;
    enc_data  = wdata_i;
    unique case (state_q)
      ecc_bank_pkg::Serve: begin
        if (req_i) begin
          mem_req_o = 1'b1;
          // A partial write starts as a read of the old word
          mem_we_o  = we_i & (&be_i);
          if (!we_i) begin
            state_d = ecc_bank_pkg::WriteBack;
          end else if (!(&be_i)) begin
            state_d = ecc_bank_pkg::Merge;
          end
        end
      end
      ecc_bank_pkg::WriteBack: begin
        // Rewrite only when the decoder fixed a bit
        mem_req_o = dec_single;
        mem_we_o  = dec_single;
        mem_add_o = add_q;
        enc_data  = dec_data;
        state_d   = ecc_bank_pkg::Serve;
      end
      ecc_bank_pkg::Merge: begin
        mem_req_o = 1'b1;
        mem_we_o  = 1'b1;
        mem_add_o = add_q;
        enc_data  = merged;
        state_d   = ecc_bank_pkg::Serve;
      end
      default: state_d = ecc_bank_pkg::Serve;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ecc_bank_pkg::Serve;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o && req_i) begin
      add_q   <= add_i;
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end
  end

endmodule

`default_nettype wire

// File: source/sram_array.sv
// Single-port SRAM model
`timescale 1ns/100ps
`default_nettype none

module sram_array #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned CodeWidth = 39,
  parameter int unsigned Depth     = 64
) (
  input  logic                     clk_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [$clog2(Depth)-1:0] addr_i,
  input  logic [CodeWidth-1:0]     wdata_i,
  output logic [CodeWidth-1:0]     rdata_o
);

  if (CodeWidth <= DataWidth) begin : gen_bad_params
    $error("Codeword must be wider than the payload");
  end

  logic [CodeWidth-1:0] mem_q [Depth];

  // Read data shows up one cycle after the request
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// File: source/secded_codec.sv
// SECDED encoder and decoder
`timescale 1ns/100ps
`default_nettype none

module secded_codec #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned CodeWidth = 39,
  parameter int unsigned Depth     = 64
) (
  input  logic [DataWidth-1:0] enc_data_i,
  output logic [CodeWidth-1:0] enc_code_o,
  input  logic [CodeWidth-1:0] dec_code_i,
  output logic [DataWidth-1:0] dec_data_o,
  output logic                 single_err_o,
  output logic                 multi_err_o
);

  // Check bits at the power-of-two positions, overall parity in bit 0
  localparam int unsigned HamBits = CodeWidth - DataWidth - 1;

  if ((1 << HamBits) < CodeWidth || Depth < 1) begin : gen_bad_params
    $error("Codeword too narrow for the payload");
  end

  logic [CodeWidth-1:0] enc_cw;
  logic [CodeWidth-1:0] corr_cw;
  logic [HamBits-1:0]   syndrome;
  logic                 parity_err;

  always_comb begin : encode
    int unsigned d;
    enc_cw = '0;
    d = 0;
    // Payload fills every non power-of-two position in order
    for (int unsigned p = 1; p < CodeWidth; p++) begin
      if ((p & (p - 1)) != 0) begin
        enc_cw[p] = enc_data_i[d];
        d++;
      end
    end
    for (int unsigned k = 0; k < HamBits; k++) begin
      for (int unsigned p = 1; p < CodeWidth; p++) begin
        if (((p >> k) & 1) != 0 && (p & (p - 1)) != 0) begin
          enc_cw[1 << k] ^= enc_cw[p];
        end
      end
    end
    enc_cw[0] = ^enc_cw;
  end

  assign enc_code_o = enc_cw;

  always_comb begin : decode
    int unsigned d;
    // XOR of all set positions points at a single flipped bit
    syndrome = '0;
    for (int unsigned p = 1; p < CodeWidth; p++) begin
      if (dec_code_i[p]) begin
        syndrome ^= HamBits'(p);
      end
    end
    parity_err   = ^dec_code_i;
    corr_cw      = dec_code_i;
    single_err_o = 1'b0;
    multi_err_o  = 1'b0;
    if (parity_err) begin
      // Syndrome beyond the codeword means more than one flip
      if (syndrome < CodeWidth) begin
        single_err_o      = 1'b1;
        corr_cw[syndrome] = ~dec_code_i[syndrome];
      end else begin
        multi_err_o = 1'b1;
      end
    end else if (syndrome != '0) begin
      multi_err_o = 1'b1;
    end
    dec_data_o = '0;
    d = 0;
    for (int unsigned p = 1; p < CodeWidth; p++) begin
      if ((p & (p - 1)) != 0) begin
        dec_data_o[d] = corr_cw[p];
        d++;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/ecc_bank_pkg.sv
// ECC cache bank definitions
`default_nettype none

package ecc_bank_pkg;

  // Payload widths and entry counts
  localparam int unsigned TagWidth  = 16;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned TagDepth  = 16;
  localparam int unsigned DataDepth = 64;

  // Data words that share one tag index
  localparam int unsigned BlocksPerIndex = DataDepth / TagDepth;

  // Payload plus Hamming bits plus the overall parity bit
  localparam int unsigned TagCodeWidth  = 22;
  localparam int unsigned DataCodeWidth = 39;

  localparam int unsigned NumBytes = DataWidth / 8;

  typedef logic [TagWidth-1:0]      tag_t;
  typedef logic [DataWidth-1:0]     data_t;
  typedef logic [TagCodeWidth-1:0]  tag_cw_t;
  typedef logic [DataCodeWidth-1:0] data_cw_t;

  typedef logic [$clog2(TagDepth)-1:0]  tag_addr_t;
  typedef logic [$clog2(DataDepth)-1:0] data_addr_t;

  typedef logic [NumBytes-1:0] data_be_t;

  typedef enum logic [1:0] {
    Idle,
    Read,
    Check
  } scrub_state_e;

  typedef enum logic [1:0] {
    Serve,
    WriteBack,
    Merge
  } wrap_state_e;

endpackage

`default_nettype wire
